// ==== Makefile ====
# Verilator build and run of the fixed-point linear layer testbench

.PHONY: all compile run clean

all: run

compile: obj_dir/sim

obj_dir/sim: build.f hdl/*.sv tests/*.sv
	verilator --binary --timing --top-module fixed_linear_tb -f build.f -o sim

# the log is searched for the pass message, so a failing run makes this target fail
run: compile
	./obj_dir/sim > run.log 2>&1; cat run.log
	grep -q "ALL TESTS PASSED" run.log

clean:
	rm -rf obj_dir run.log

// ==== build.f ====
hdl/linear_pkg.sv
hdl/linear_input_fifo.sv
hdl/dot_product_lane.sv
hdl/bias_output_stage.sv
hdl/fixed_linear_top.sv
tests/fixed_linear_tb.sv

// ==== hdl/bias_output_stage.sv ====
`timescale 1ns/1ns

// adds each lane's bias, holds one result and sends it out under output credit control
module bias_output_stage (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic                                                   result_valid,
  input  linear_pkg::lane_result_t [linear_pkg::PARALLELISM-1:0] result,
  output logic                                                   lane_ready,
  output logic                                                   out_valid,
  output linear_pkg::out_beat_t                                  out_beat,
  input  logic                                                   out_credit
);

  linear_pkg::out_beat_t                   sum_beat;
  linear_pkg::out_beat_t                   hold_beat;
  logic                                    hold_valid;
  logic                                    send;
  logic [linear_pkg::CREDIT_CNT_WIDTH-1:0] credit_cnt;

  // with zero fractional bits the bias cast is a plain sign extension
  always_comb begin
    linear_pkg::out_word_t acc_ext;
    linear_pkg::out_word_t bias_ext;
    for (int i = 0; i < linear_pkg::PARALLELISM; i++) begin
      acc_ext  = {{(linear_pkg::OUT_WIDTH - linear_pkg::ACC_WIDTH)
                   {result[i].acc[linear_pkg::ACC_WIDTH-1]}},
                  result[i].acc};
      bias_ext = {{(linear_pkg::OUT_WIDTH - linear_pkg::BIAS_WIDTH)
                   {result[i].bias[linear_pkg::BIAS_WIDTH-1]}},
                  result[i].bias};
      sum_beat.value[i] = acc_ext + bias_ext;
    end
  end

  // the lanes may finish a group only while nothing is waiting here
  assign lane_ready = ~hold_valid;

  // a held result goes out as soon as the sink has a free slot
  assign out_valid = hold_valid & (credit_cnt != '0);
  assign send      = out_valid;
  assign out_beat  = hold_beat;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
    end else begin
      hold_valid <= result_valid | (hold_valid & ~send);
    end
  end

  always_ff @(posedge clk) begin
    if (result_valid) begin
      hold_beat <= sum_beat;
    end
  end

  // one credit is spent per send and one returns per out_credit pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= linear_pkg::CREDIT_CNT_WIDTH'(linear_pkg::OUT_CREDITS);
    end else begin
      case ({send, out_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

// ==== hdl/dot_product_lane.sv ====
`timescale 1ns/1ns

// one output channel of the linear layer
// stage 1 registers the dot product of a single beat, stage 2 accumulates IN_DEPTH of them
module dot_product_lane (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     pop_valid,
  input  linear_pkg::act_vec_t     data,
  input  linear_pkg::weight_vec_t  weight,
  input  linear_pkg::bias_t        bias,
  input  logic                     lane_ready,
  output logic                     result_valid,
  output linear_pkg::lane_result_t result
);

  logic                                     accept;
  logic                                     last_beat;
  logic [linear_pkg::BEAT_CNT_WIDTH-1:0]    beat_cnt;
  logic signed [linear_pkg::FDP_WIDTH-1:0]  prod_sum;
  logic signed [linear_pkg::FDP_WIDTH-1:0]  fdp_q;
  logic                                     fdp_valid;
  logic                                     fdp_first;
  logic                                     fdp_last;
  logic signed [linear_pkg::ACC_WIDTH-1:0]  acc_q;
  linear_pkg::bias_t                        bias_q;

  // beats are taken only while the output stage has room
  assign accept    = pop_valid & lane_ready;
  assign last_beat = (beat_cnt == linear_pkg::BEAT_CNT_WIDTH'(linear_pkg::IN_DEPTH - 1));

  // signed multiply of each element pair, summed at full dot-product width
  always_comb begin
    prod_sum = '0;
    for (int i = 0; i < linear_pkg::IN_SIZE; i++) begin
      prod_sum = prod_sum + linear_pkg::FDP_WIDTH'(data[i] * weight[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt     <= '0;
      fdp_valid    <= 1'b0;
      fdp_first    <= 1'b0;
      fdp_last     <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      fdp_valid    <= accept;
      fdp_first    <= (beat_cnt == '0);
      fdp_last     <= last_beat;
      result_valid <= fdp_valid & fdp_last;
      if (accept) begin
        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
      end
    end
  end

  // payload registers that travel alongside the valid flags above
  always_ff @(posedge clk) begin
    if (accept) begin
      fdp_q <= prod_sum;
      if (last_beat) begin
        bias_q <= bias;
      end
    end
    // the first beat of a group starts the sum afresh
    if (fdp_valid) begin
      acc_q <= (fdp_first ? '0 : acc_q) + linear_pkg::ACC_WIDTH'(fdp_q);
    end
  end

  assign result.acc  = acc_q;
  assign result.bias = bias_q;

endmodule

// ==== hdl/fixed_linear_top.sv ====
`timescale 1ns/1ns

// fixed-point linear layer with credit flow control on both ports
// beats are buffered, fed to PARALLELISM dot-product lanes in lockstep,
// and the lane sums get their biases added in a shared output stage
module fixed_linear_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  linear_pkg::in_beat_t  in_beat,
  output logic                  in_credit,
  output logic                  out_valid,
  output linear_pkg::out_beat_t out_beat,
  input  logic                  out_credit
);

  logic                                                   pop_valid;
  linear_pkg::in_beat_t                                   pop_beat;
  logic                                                   lane_ready;
  logic [linear_pkg::PARALLELISM-1:0]                     lane_valid;
  linear_pkg::lane_result_t [linear_pkg::PARALLELISM-1:0] lane_result;

  linear_input_fifo fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .in_credit  (in_credit),
    .lane_ready (lane_ready),
    .pop_valid  (pop_valid),
    .pop_beat   (pop_beat)
  );

  // every lane sees the same activations and takes its own weight slice and bias
  for (genvar i = 0; i < linear_pkg::PARALLELISM; i++) begin : lane_gen
    dot_product_lane lane_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .pop_valid    (pop_valid),
      .data         (pop_beat.data),
      .weight       (pop_beat.weight[i]),
      .bias         (pop_beat.bias[i]),
      .lane_ready   (lane_ready),
      .result_valid (lane_valid[i]),
      .result       (lane_result[i])
    );
  end

  // lanes are fed identical pops, so lane 0's pulse stands for all of them
  bias_output_stage stage_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .result_valid (lane_valid[0]),
    .result       (lane_result),
    .lane_ready   (lane_ready),
    .out_valid    (out_valid),
    .out_beat     (out_beat),
    .out_credit   (out_credit)
  );

endmodule

// ==== hdl/linear_input_fifo.sv ====
`timescale 1ns/1ns

// circular buffer for incoming beats
// the source only sends while it holds a credit, so the buffer is never written while full
module linear_input_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  linear_pkg::in_beat_t in_beat,
  output logic                 in_credit,
  input  logic                 lane_ready,
  output logic                 pop_valid,
  output linear_pkg::in_beat_t pop_beat
);

  linear_pkg::in_beat_t mem [linear_pkg::IN_CREDITS];

  // the extra top bit tells a full buffer apart from an empty one
  logic [linear_pkg::FIFO_PTR_WIDTH:0] wr_ptr;
  logic [linear_pkg::FIFO_PTR_WIDTH:0] rd_ptr;
  logic [linear_pkg::FIFO_PTR_WIDTH-1:0] wr_addr;
  logic [linear_pkg::FIFO_PTR_WIDTH-1:0] rd_addr;
  logic pop;

  assign wr_addr = wr_ptr[linear_pkg::FIFO_PTR_WIDTH-1:0];
  assign rd_addr = rd_ptr[linear_pkg::FIFO_PTR_WIDTH-1:0];

  // head of the buffer is offered as soon as the write pointer has moved past it
  assign pop_valid = (wr_ptr != rd_ptr);
  assign pop_beat  = mem[rd_addr];

  // a beat leaves only when the lanes take it
  assign pop = pop_valid & lane_ready;

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_addr] <= in_beat;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // each freed slot goes back to the source as one credit, a cycle after the pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_credit <= 1'b0;
    end else begin
      in_credit <= pop;
    end
  end

endmodule

// ==== hdl/linear_pkg.sv ====
package linear_pkg;

  // element widths and vector shape
  localparam int IN_WIDTH     = 8;
  localparam int WEIGHT_WIDTH = 8;
  localparam int IN_SIZE      = 4;
  localparam int IN_DEPTH     = 3;
  localparam int PARALLELISM  = 2;
  localparam int BIAS_WIDTH   = 16;

  // one beat's dot product, then the sum over IN_DEPTH beats, then one bit for the bias add
  localparam int FDP_WIDTH = IN_WIDTH + WEIGHT_WIDTH + $clog2(IN_SIZE);
  localparam int ACC_WIDTH = FDP_WIDTH + $clog2(IN_DEPTH);
  localparam int OUT_WIDTH = ACC_WIDTH + 1;

  // credit depths on the two ports
  localparam int IN_CREDITS  = 4;
  localparam int OUT_CREDITS = 2;

  // counter and pointer widths derived from the sizes above
  localparam int FIFO_PTR_WIDTH   = $clog2(IN_CREDITS);
  localparam int BEAT_CNT_WIDTH   = $clog2(IN_DEPTH);
  localparam int CREDIT_CNT_WIDTH = $clog2(OUT_CREDITS + 1);

  typedef logic signed [IN_WIDTH-1:0]     act_t;
  typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;
  typedef logic signed [BIAS_WIDTH-1:0]   bias_t;
  typedef logic signed [OUT_WIDTH-1:0]    out_word_t;

  typedef act_t    [IN_SIZE-1:0] act_vec_t;
  typedef weight_t [IN_SIZE-1:0] weight_vec_t;

  // one input beat carries the activations, every lane's weight slice and every lane's bias
  typedef struct packed {
    act_vec_t                      data;
    weight_vec_t [PARALLELISM-1:0] weight;
    bias_t       [PARALLELISM-1:0] bias;
  } in_beat_t;

  // what a lane hands to the output stage once a group is complete
  typedef struct packed {
    logic signed [ACC_WIDTH-1:0] acc;
    bias_t                       bias;
  } lane_result_t;

  typedef struct packed {
    out_word_t [PARALLELISM-1:0] value;
  } out_beat_t;

endpackage

// ==== tests/fixed_linear_tb.sv ====
`timescale 1ns/1ns

module fixed_linear_tb;

  localparam logic [31:0] SEED = 32'hda7caf5b;
  // the five tests send 1, 20, 5, 6 and 2 groups
  localparam int TOTAL_GROUPS = 34;
  localparam int CYCLE_LIMIT  = 40 * TOTAL_GROUPS + 200;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  in_valid;
  linear_pkg::in_beat_t  in_beat;
  logic                  in_credit;
  logic                  out_valid;
  linear_pkg::out_beat_t out_beat;
  logic                  out_credit = 1'b0;

  // the comparator walks these expected results by index in send order
  linear_pkg::out_beat_t exp_q [$];

  logic [31:0] stim_state;
  logic [31:0] sink_state = SEED;
  int          beats_sent;
  int          sink_delay_max;
  bit          sink_hold;
  int          errors;
  int          checks;
  int          tests_passed;
  int          tests_failed;
  int          in_credit_cnt = 0;
  int          recv_cnt = 0;
  int          credits_given = 0;
  int          sink_wait = 0;
  int          out_errors = 0;
  int          out_checks = 0;
  int          cycle_cnt = 0;

  fixed_linear_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_credit (out_credit)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  // the upper half of the LCG word is the better mixed part
  function automatic int rand_below(inout logic [31:0] state, input int n);
    return int'(lcg_step(state) >> 16) % n;
  endfunction

  function automatic linear_pkg::in_beat_t random_beat(inout logic [31:0] state);
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    w0 = lcg_step(state);
    w1 = lcg_step(state);
    w2 = lcg_step(state);
    w3 = lcg_step(state);
    return {w3, w2, w1, w0};
  endfunction

  // each channel is the dot product over the whole group plus the last beat's bias
  function automatic linear_pkg::out_beat_t linear_ref(
    input linear_pkg::in_beat_t beats [linear_pkg::IN_DEPTH]
  );
    linear_pkg::out_beat_t res;
    int                    sum;
    for (int l = 0; l < linear_pkg::PARALLELISM; l++) begin
      sum = 0;
      for (int b = 0; b < linear_pkg::IN_DEPTH; b++) begin
        for (int e = 0; e < linear_pkg::IN_SIZE; e++) begin
          sum += int'(beats[b].data[e]) * int'(beats[b].weight[l][e]);
        end
      end
      sum += int'(beats[linear_pkg::IN_DEPTH-1].bias[l]);
      res.value[l] = linear_pkg::out_word_t'(sum);
    end
    return res;
  endfunction

  task automatic check_out(input string what, input linear_pkg::out_beat_t got,
                           input linear_pkg::out_beat_t want);
    out_checks++;
    for (int l = 0; l < linear_pkg::PARALLELISM; l++) begin
      if (got.value[l] !== want.value[l]) begin
        out_errors++;
        $display("mismatch at %0t: %s lane %0d is %0d, expected %0d", $time, what, l,
                 $signed(got.value[l]), $signed(want.value[l]));
      end
    end
  endtask

  task automatic check_count(input string what, input int got, input int want);
    checks++;
    if (got != want) begin
      errors++;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  // outputs are sampled at the rising edge, where they still hold the last cycle's values
  always @(posedge clk) begin
    if (rst_n) begin
      if (in_credit) begin
        in_credit_cnt++;
        if (in_credit_cnt > beats_sent) begin
          out_errors++;
          $display("the DUT returned more input credits than beats were sent at %0t", $time);
        end
      end
      if (out_valid) begin
        if (recv_cnt >= exp_q.size()) begin
          out_errors++;
          $display("an output beat appeared with no group outstanding at %0t", $time);
        end else begin
          check_out("output beat", out_beat, exp_q[recv_cnt]);
        end
        recv_cnt++;
        if (recv_cnt - credits_given > linear_pkg::OUT_CREDITS) begin
          out_errors++;
          $display("the DUT sent a result while the sink had no free slot at %0t", $time);
        end
      end
    end
  end

  // the sink frees one slot per consumed result after a random delay
  always @(negedge clk) begin
    out_credit = 1'b0;
    if (rst_n && !sink_hold && recv_cnt > credits_given) begin
      if (sink_wait > 0) begin
        sink_wait--;
      end else begin
        out_credit = 1'b1;
        credits_given++;
        sink_wait = (sink_delay_max > 0) ? rand_below(sink_state, sink_delay_max + 1) : 0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // called on a falling edge and returns on the next one
  task automatic send_beat(input linear_pkg::in_beat_t beat);
    while (linear_pkg::IN_CREDITS + in_credit_cnt - beats_sent <= 0) begin
      @(negedge clk);
    end
    in_valid = 1'b1;
    in_beat  = beat;
    beats_sent++;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic send_group(input linear_pkg::in_beat_t beats [linear_pkg::IN_DEPTH],
                            input int gap_max);
    int gap;
    exp_q.push_back(linear_ref(beats));
    for (int b = 0; b < linear_pkg::IN_DEPTH; b++) begin
      send_beat(beats[b]);
      if (gap_max > 0) begin
        gap = rand_below(stim_state, gap_max + 1);
        repeat (gap) @(negedge clk);
      end
    end
  endtask

  task automatic send_random_groups(input int count, input int gap_max);
    linear_pkg::in_beat_t beats [linear_pkg::IN_DEPTH];
    for (int g = 0; g < count; g++) begin
      for (int b = 0; b < linear_pkg::IN_DEPTH; b++) begin
        beats[b] = random_beat(stim_state);
      end
      send_group(beats, gap_max);
    end
  endtask

  task automatic wait_idle();
    while (recv_cnt != exp_q.size() || credits_given != recv_cnt) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors + out_errors == errs_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors + out_errors - errs_before);
    end
  endtask

  task automatic test_fixed_group();
    linear_pkg::in_beat_t beats [linear_pkg::IN_DEPTH];
    int                   errs;
    errs = errors + out_errors;
    for (int b = 0; b < linear_pkg::IN_DEPTH; b++) begin
      for (int e = 0; e < linear_pkg::IN_SIZE; e++) begin
        beats[b].data[e]      = linear_pkg::act_t'(4 * b + e + 1);
        beats[b].weight[0][e] = linear_pkg::weight_t'(e + 1);
        beats[b].weight[1][e] = linear_pkg::weight_t'(3 - 2 * e + b);
      end
      // biases differ per beat so a capture from the wrong beat shows up
      beats[b].bias[0] = linear_pkg::bias_t'(10 * b - 7);
      beats[b].bias[1] = linear_pkg::bias_t'(300 - 200 * b);
    end
    send_group(beats, 0);
    wait_idle();
    report_test("fixed group", errs);
  endtask

  task automatic test_random_stream();
    int errs;
    errs = errors + out_errors;
    sink_delay_max = 0;
    send_random_groups(20, 0);
    wait_idle();
    report_test("random back to back", errs);
  endtask

  task automatic test_output_backpressure();
    int errs;
    int recv0;
    errs  = errors + out_errors;
    recv0 = recv_cnt;
    sink_hold = 1'b1;
    fork
      send_random_groups(5, 0);
      begin
        repeat (60) @(negedge clk);
        check_count("results while credits are withheld", recv_cnt - recv0,
                    linear_pkg::OUT_CREDITS);
        @(posedge clk);
        sink_hold = 1'b0;
      end
    join
    wait_idle();
    report_test("output back-pressure", errs);
  endtask

  task automatic test_credit_accounting();
    int errs;
    int beats0;
    int credits0;
    errs     = errors + out_errors;
    beats0   = beats_sent;
    credits0 = in_credit_cnt;
    sink_delay_max = 7;
    send_random_groups(6, 3);
    wait_idle();
    check_count("in_credit pulses", in_credit_cnt - credits0, beats_sent - beats0);
    check_count("source credits when idle", linear_pkg::IN_CREDITS + in_credit_cnt - beats_sent,
                linear_pkg::IN_CREDITS);
    sink_delay_max = 0;
    report_test("input credit accounting", errs);
  endtask

  task automatic test_extreme_values();
    linear_pkg::in_beat_t beats [linear_pkg::IN_DEPTH];
    int                   errs;
    errs = errors + out_errors;
    for (int g = 0; g < 2; g++) begin
      for (int b = 0; b < linear_pkg::IN_DEPTH; b++) begin
        for (int e = 0; e < linear_pkg::IN_SIZE; e++) begin
          beats[b].data[e]      = linear_pkg::act_t'(-128);
          beats[b].weight[0][e] = linear_pkg::weight_t'(-128);
          beats[b].weight[1][e] = linear_pkg::weight_t'(-128);
        end
        beats[b].bias[0] = linear_pkg::bias_t'((g == 0) ? 32767 : -32768);
        beats[b].bias[1] = linear_pkg::bias_t'((g == 0) ? -32768 : 32767);
      end
      send_group(beats, 0);
    end
    wait_idle();
    report_test("extreme values", errs);
  endtask

  initial begin
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    in_beat        = '0;
    stim_state     = SEED;
    beats_sent     = 0;
    sink_delay_max = 0;
    sink_hold      = 1'b0;
    errors         = 0;
    checks         = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    repeat (10) @(negedge clk);
    check_count("out_valid during reset", int'(out_valid), 0);
    check_count("in_credit during reset", int'(in_credit), 0);
    rst_n = 1'b1;
    @(negedge clk);

    test_fixed_group();
    test_random_stream();
    test_output_backpressure();
    test_credit_accounting();
    test_extreme_values();

    $display("%0d tests passed, %0d failed, %0d checks, %0d errors", tests_passed,
             tests_failed, checks + out_checks, errors + out_errors);
    if (errors + out_errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
